//--- monitor_pkg.sv
package monitor_pkg;

	// ****************************************
	// system time and heartbeat
	// ****************************************

	// width of the free-running system time
	localparam int time_bits = 64;

	// one-hot heartbeat pattern on the board LEDs
	localparam int led_count = 8;
	localparam logic [led_count-1:0] led_init = led_count'(1);

	// rotate once every 2^heartbeat_bits cycles
	localparam int heartbeat_bits = 10;

	// ****************************************
	// step supervision
	// ****************************************

	// watched motion step outputs
	localparam int step_channels = 6;

	// idle cycles before a channel reports an alert
	localparam int idle_limit = 2000;
	localparam int idle_bits = $clog2(idle_limit + 1);

	// only this channel may request a shutdown
	localparam int watch_channel = 5;

	// flip-flops on every asynchronous board input
	localparam int sync_stages = 2;

endpackage

//--- system_timer.sv
`timescale 1ns/10ps

module system_timer
	import monitor_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 time_set_en,
	input  logic [time_bits-1:0] time_set,
	output logic [time_bits-1:0] systime,
	output logic [led_count-1:0] leds
);

	// low bits of the current time all zero
	logic heartbeat_wrap;

	assign heartbeat_wrap = (systime[heartbeat_bits-1:0] == '0);

	// ****************************************
	// system time
	// ****************************************

	// host load wins over the increment
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			systime <= '0;
		end else if (time_set_en) begin
			systime <= time_set;
		end else begin
			systime <= systime + time_bits'(1);
		end
	end

	// ****************************************
	// heartbeat LEDs
	// ****************************************

	// rotate left, msb wraps around to bit 0
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			leds <= led_init;
		end else if (heartbeat_wrap) begin
			leds <= {leds[led_count-2:0], leds[led_count-1]};
		end
	end

	// a lost or doubled LED bit would never recover by rotation
	assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot(leds)
	);

endmodule

//--- step_activity_capture.sv
`timescale 1ns/10ps

module step_activity_capture
	import monitor_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [step_channels-1:0] step,
	input  logic                     arm_endstop,
	output logic [step_channels-1:0] activity,
	output logic                     armed
);

	// synchronizer chains, last stage is the usable one
	logic [step_channels-1:0] step_sync [sync_stages];
	logic [sync_stages-1:0]   endstop_sync;

	// synchronized step levels of the previous cycle
	logic [step_channels-1:0] step_prev;

	// ****************************************
	// input synchronizers
	// ****************************************

	// endstop idles high, so its chain resets high to avoid a false arm
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < sync_stages; i++) begin
				step_sync[i] <= '0;
			end
			endstop_sync <= '1;
		end else begin
			step_sync[0] <= step;
			for (int i = 1; i < sync_stages; i++) begin
				step_sync[i] <= step_sync[i-1];
			end
			endstop_sync <= {endstop_sync[sync_stages-2:0], arm_endstop};
		end
	end

	// ****************************************
	// toggle detect and arming
	// ****************************************

	// one pulse per edge of either polarity
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			step_prev <= '0;
			activity  <= '0;
		end else begin
			step_prev <= step_sync[sync_stages-1];
			activity  <= step_sync[sync_stages-1] ^ step_prev;
		end
	end

	// sticky until reset, endstop is active low
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			armed <= 1'b0;
		end else if (!endstop_sync[sync_stages-1]) begin
			armed <= 1'b1;
		end
	end

endmodule

//--- step_idle_timer.sv
`timescale 1ns/10ps

module step_idle_timer
	import monitor_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic activity,
	output logic alert
);

	localparam logic [idle_bits-1:0] idle_max = idle_bits'(idle_limit);

	// cycles since the last step activity
	logic [idle_bits-1:0] idle_count;
	logic                 idle_full;

	assign idle_full = (idle_count == idle_max);

	// ****************************************
	// idle counter
	// ****************************************

	// any activity restarts the count, otherwise hold at the limit
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idle_count <= '0;
		end else if (activity) begin
			idle_count <= '0;
		end else if (!idle_full) begin
			idle_count <= idle_count + idle_bits'(1);
		end
	end

	// level, stays up for as long as the channel is silent
	assign alert = idle_full;

	// counter must saturate, never wrap past the limit
	assert property (
		@(posedge clk) disable iff (!rst_n)
		idle_count <= idle_max
	);

endmodule

//--- shutdown_guard.sv
`timescale 1ns/10ps

module shutdown_guard
	import monitor_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [step_channels-1:0] alert,
	input  logic                     armed,
	output logic                     req_shutdown
);

	// alert of the channel that guards the machine
	logic watch_alert;
	logic trip;

	assign watch_alert = alert[watch_channel];

	// an idle channel only counts once the endstop has armed us
	assign trip = watch_alert & armed;

	// ****************************************
	// shutdown latch
	// ****************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			req_shutdown <= 1'b0;
		end else if (trip) begin
			req_shutdown <= 1'b1;
		end
	end

	// resumed steps must not release the request
	assert property (
		@(posedge clk) disable iff (!rst_n)
		req_shutdown |=> req_shutdown
	);

endmodule

//--- board_monitor.sv
`timescale 1ns/10ps

module board_monitor
	import monitor_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     time_set_en,
	input  logic [time_bits-1:0]     time_set,
	input  logic [step_channels-1:0] step,
	input  logic                     arm_endstop,
	output logic [time_bits-1:0]     systime,
	output logic [led_count-1:0]     leds,
	output logic [step_channels-1:0] alert,
	output logic                     req_shutdown
);

	logic [step_channels-1:0] activity;
	logic                     armed;

	// ****************************************
	// system time and heartbeat
	// ****************************************

	system_timer i_system_timer (
		.clk         (clk),
		.rst_n       (rst_n),
		.time_set_en (time_set_en),
		.time_set    (time_set),
		.systime     (systime),
		.leds        (leds)
	);

	// ****************************************
	// step watcher
	// ****************************************

	step_activity_capture i_step_activity_capture (
		.clk         (clk),
		.rst_n       (rst_n),
		.step        (step),
		.arm_endstop (arm_endstop),
		.activity    (activity),
		.armed       (armed)
	);

	// one idle timer per step output
	for (genvar ch = 0; ch < step_channels; ch++) begin : g_idle
		step_idle_timer i_step_idle_timer (
			.clk      (clk),
			.rst_n    (rst_n),
			.activity (activity[ch]),
			.alert    (alert[ch])
		);
	end

	shutdown_guard i_shutdown_guard (
		.clk          (clk),
		.rst_n        (rst_n),
		.alert        (alert),
		.armed        (armed),
		.req_shutdown (req_shutdown)
	);

endmodule

//--- board_monitor_tb.sv
`timescale 1ns/10ps

module board_monitor_tb
	import monitor_pkg::*;
();

	localparam int max_steps     = 64;
	localparam int margin_cycles = 200;
	localparam int never         = 32'h7fffffff;

	logic                     clk;
	logic                     rst_n;
	logic                     time_set_en;
	logic [time_bits-1:0]     time_set;
	logic [step_channels-1:0] step;
	logic                     arm_endstop;
	logic [time_bits-1:0]     systime;
	logic [led_count-1:0]     leds;
	logic [step_channels-1:0] alert;
	logic                     req_shutdown;

	// four words per step: op, value, cycles, expected
	logic [63:0] testdata [0:4*max_steps-1];

	// values applied at the next rising edge
	logic                     rst_next;
	logic                     load_next;
	logic [time_bits-1:0]     load_value;
	logic                     arm_next;
	logic [step_channels-1:0] active;
	logic [step_channels-1:0] toggle_once;

	// ****************************************
	// reference model state
	// ****************************************

	logic [time_bits-1:0]     sys_exp;
	logic [led_count-1:0]     leds_exp;
	logic [step_channels-1:0] alert_exp;
	logic                     armed_exp;
	logic                     req_exp;
	int                       idle_exp [step_channels];
	logic [step_channels-1:0] toggle_hist [4];
	int                       last_drive [step_channels];
	int                       arm_edge;
	int                       edge_no;

	integer seed;
	int     errors;
	int     checks;
	int     cycle_limit;
	int     cycles_run;

	board_monitor i_board_monitor (
		.clk          (clk),
		.rst_n        (rst_n),
		.time_set_en  (time_set_en),
		.time_set     (time_set),
		.step         (step),
		.arm_endstop  (arm_endstop),
		.systime      (systime),
		.leds         (leds),
		.alert        (alert),
		.req_shutdown (req_shutdown)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
		end
	endtask

	// one clock: update the model, drive inputs, then compare at the falling edge
	task automatic advance_cycle();
		logic [31:0]              rnd;
		logic [step_channels-1:0] toggles;
		logic [step_channels-1:0] clear;
		@(posedge clk);
		edge_no++;
		if (!rst_n) begin
			sys_exp  = '0;
			leds_exp = led_count'(1);
			req_exp  = 1'b0;
			for (int ch = 0; ch < step_channels; ch++) begin
				idle_exp[ch] = 0;
			end
			for (int i = 0; i < 4; i++) begin
				toggle_hist[i] = '0;
			end
		end else begin
			if (alert_exp[watch_channel] && armed_exp) begin
				req_exp = 1'b1;
			end
			if (sys_exp[heartbeat_bits-1:0] == '0) begin
				leds_exp = {leds_exp[led_count-2:0], leds_exp[led_count-1]};
			end
			sys_exp = time_set_en ? time_set : sys_exp + time_bits'(1);
			// toggle driven four edges ago clears the count now
			clear = toggle_hist[3];
			for (int ch = 0; ch < step_channels; ch++) begin
				if (clear[ch]) begin
					idle_exp[ch] = 0;
				end else if (idle_exp[ch] < idle_limit) begin
					idle_exp[ch]++;
				end
			end
		end
		for (int i = 3; i > 0; i--) begin
			toggle_hist[i] = toggle_hist[i-1];
		end
		for (int ch = 0; ch < step_channels; ch++) begin
			alert_exp[ch] = (idle_exp[ch] == idle_limit);
		end
		armed_exp = (edge_no >= arm_edge);

		// random toggles, forced well before the idle limit
		rnd = $random(seed);
		toggles = active & rnd[step_channels-1:0] & rnd[2*step_channels-1:step_channels];
		for (int ch = 0; ch < step_channels; ch++) begin
			if (active[ch] && edge_no - last_drive[ch] >= idle_limit / 4) begin
				toggles[ch] = 1'b1;
			end
		end
		toggles = toggles | toggle_once;
		for (int ch = 0; ch < step_channels; ch++) begin
			if (toggles[ch]) begin
				last_drive[ch] = edge_no;
			end
		end
		toggle_hist[0] = toggles;
		if (!arm_next && arm_edge == never) begin
			arm_edge = edge_no + 3;
		end
		step        <= step ^ toggles;
		rst_n       <= rst_next;
		time_set_en <= load_next;
		time_set    <= load_value;
		arm_endstop <= arm_next;

		@(negedge clk);
		check_value("systime", systime, sys_exp);
		check_value("leds", 64'(leds), 64'(leds_exp));
		check_value("leds set bits", 64'($countones(leds)), 64'd1);
		check_value("alert", 64'(alert), 64'(alert_exp));
		check_value("req_shutdown", 64'(req_shutdown), 64'(req_exp));
	endtask

	// silence one channel and measure when its alert rises
	task automatic wait_alert(input int ch, input int limit, input logic [63:0] expected);
		int waited;
		int latency;
		waited = 0;
		active[ch] = 1'b0;
		while (!alert[ch] && waited < limit) begin
			advance_cycle();
			waited++;
		end
		if (!alert[ch]) begin
			errors++;
			$display("alert on channel %0d did not rise within %0d cycles", ch, limit);
		end else begin
			latency = edge_no - (last_drive[ch] + 1);
			check_value("alert latency", 64'(latency), expected);
			if (latency < idle_limit || latency > idle_limit + 3) begin
				errors++;
				$display("alert on channel %0d rose after %0d cycles, out of range", ch, latency);
			end
		end
	endtask

	initial begin : run_limit
		cycles_run = 0;
		do begin
			@(posedge clk);
			cycles_run++;
		end while (cycles_run <= cycle_limit);
		$display("timeout: run did not finish within %0d cycles", cycle_limit);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int          idx;
		int          op;
		int          cycles;
		logic [63:0] value;
		logic [63:0] expected;
		rst_n = 1'b0;
		time_set_en = 1'b0;
		time_set = '0;
		step = '0;
		arm_endstop = 1'b1;
		rst_next = 1'b0;
		load_next = 1'b0;
		load_value = '0;
		arm_next = 1'b1;
		active = '0;
		toggle_once = '0;
		alert_exp = '0;
		armed_exp = 1'b0;
		req_exp = 1'b0;
		arm_edge = never;
		edge_no = 0;
		for (int ch = 0; ch < step_channels; ch++) begin
			last_drive[ch] = 0;
		end
		seed = 32'h60b1;
		errors = 0;
		checks = 0;
		$readmemh("monitor_testdata.txt", testdata);

		// limit from the sum of all step lengths
		cycle_limit = 16 + margin_cycles;
		idx = 0;
		while (idx < 4 * max_steps && int'(testdata[idx]) != 0) begin
			cycle_limit += int'(testdata[idx+2]) + 4;
			idx += 4;
		end

		repeat (15) advance_cycle();
		rst_next = 1'b1;
		advance_cycle();

		idx = 0;
		while (idx < 4 * max_steps && int'(testdata[idx]) != 0) begin
			op       = int'(testdata[idx]);
			value    = testdata[idx+1];
			cycles   = int'(testdata[idx+2]);
			expected = testdata[idx+3];
			case (op)
				1: begin
					active = value[step_channels-1:0];
					repeat (cycles) advance_cycle();
					check_value("alert", 64'(alert), expected);
				end
				2: begin
					load_next  = 1'b1;
					load_value = value;
					advance_cycle();
					load_next = 1'b0;
					repeat (cycles + 1) advance_cycle();
					check_value("systime", systime, expected);
				end
				3: wait_alert(int'(value), cycles, expected);
				4: begin
					toggle_once = value[step_channels-1:0];
					advance_cycle();
					toggle_once = '0;
					repeat (cycles) advance_cycle();
					check_value("alert", 64'(alert), expected);
				end
				5: begin
					arm_next = value[0];
					repeat (cycles) advance_cycle();
					check_value("req_shutdown", 64'(req_shutdown), expected);
				end
				default: begin
					errors++;
					$display("unknown operation %0d in data step %0d", op, idx / 4);
				end
			endcase
			idx += 4;
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- monitor_testdata.txt
// board monitor stimulus, all fields hex
// columns: op value cycles expected
// op 1 random steps on the channels in value, expected alert vector at the end
// op 2 load value into system time, expected systime cycles after the load
// op 3 silence channel value, cycles is the wait limit, expected alert latency
// op 4 toggle the channels in value once, expected alert vector cycles later
// op 5 drive arm_endstop to value, expected req_shutdown cycles later
// op 0 ends the run

// after reset, all channels busy
1 3f 80 0
1 3f 400 0

// host time loads
2 1000 14 1014
2 3fd a 407
2 3ff 1 400
2 0 0 0
2 123456789abcdef0 5 123456789abcdef5
2 ffffffffffffff00 12c 2c
2 7ffffffffffffffe 4 8000000000000002

// heartbeat over several wraps
2 fff00 100 100000
1 3f 900 0

// watched channel idles before arming
5 1 20 0
3 5 800 7d3
5 1 40 0
4 20 6 0
1 3f 100 0

// every other channel idles once
3 0 800 7d3
4 1 6 0
1 3f 40 0
3 1 800 7d3
4 2 6 0
1 3f 40 0
3 2 800 7d3
4 4 6 0
1 3f 40 0
3 3 800 7d3
4 8 6 0
1 3f 40 0
3 4 800 7d3
4 10 6 0
1 3f 40 0

// several channels silent at once
1 a 900 35
4 35 6 0
1 3f 80 0
1 15 900 2a
4 2a 6 0
1 3f 80 0

// arm, then idle the watched channel
5 0 10 0
5 1 20 0
3 5 800 7d3
5 1 4 1
1 3f 100 0
5 0 40 1
1 3f 200 0

0 0 0 0

//--- build.f
monitor_pkg.sv
system_timer.sv
step_activity_capture.sv
step_idle_timer.sv
shutdown_guard.sv
board_monitor.sv
board_monitor_tb.sv

//--- Makefile
TOP = board_monitor_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module board_monitor

sim:
	verilator --binary --timing -j 0 -f build.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf obj_dir
